//--- verilog/ttt_pkg.sv
`default_nettype none

// shared types for the tic-tac-toe engine, referenced everywhere as ttt_pkg::name
package ttt_pkg;

	// the board is a 3x3 grid, numbered row by row from the top left
	localparam int CELL_COUNT = 9;

	// cell index as it arrives on the move channel
	// values 9 to 15 do not name a cell and are refused
	typedef logic [3:0] cell_idx_t;

	// one bit per cell, bit n is cell n
	typedef logic [CELL_COUNT-1:0] cell_mask_t;

	// whose turn it is, or who owns something
	typedef enum logic [1:0] {
		NONE = 2'd0,
		X    = 2'd1,
		O    = 2'd2
	} player_t;

	// occupancy of the board, one mask per player
	typedef struct packed {
		cell_mask_t x_cells;
		cell_mask_t o_cells;
	} board_t;

	// what the line checker found on the current board
	typedef struct packed {
		logic x_line;
		logic o_line;
		logic full;
	} line_result_t;

	// outcome of the game so far
	typedef enum logic [1:0] {
		IN_PLAY = 2'd0,
		X_WINS  = 2'd1,
		O_WINS  = 2'd2,
		DRAW    = 2'd3
	} game_result_t;

	// elapsed play time as four BCD digits, mm:ss
	typedef struct packed {
		logic [3:0] min_tens;
		logic [3:0] min_ones;
		logic [3:0] sec_tens;
		logic [3:0] sec_ones;
	} bcd_time_t;

	// everything the outside sees about the game apart from the board
	typedef struct packed {
		game_result_t result;
		player_t      turn;
		bcd_time_t    elapsed;
	} game_status_t;

endpackage

`default_nettype wire

//--- verilog/line_checker.sv
`timescale 1ns/1ps
`default_nettype none

// purely combinational look at the board
// it answers three questions: does X hold a line, does O hold a line, is every cell taken
module line_checker (
	input  wire ttt_pkg::board_t       board,
	output ttt_pkg::line_result_t      lines
);

	// the eight winning lines as cell masks
	// rows first, then columns, then the two diagonals
	localparam logic [7:0][ttt_pkg::CELL_COUNT-1:0] WIN_LINES = {
		9'b001_010_100,
		9'b100_010_001,
		9'b100_100_100,
		9'b010_010_010,
		9'b001_001_001,
		9'b111_000_000,
		9'b000_111_000,
		9'b000_000_111
	};

	// union of both players, used for the full-board test
	ttt_pkg::cell_mask_t taken;

	// true when the given mask covers at least one complete line
	// the same test serves both players
	function automatic logic holds_line(input ttt_pkg::cell_mask_t mask);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < 8; i++)
		begin
			// every cell of the line must be present in the mask
			if ((mask & WIN_LINES[i]) == WIN_LINES[i])
				hit = 1'b1;
		end
		return hit;
	endfunction

	assign taken = board.x_cells | board.o_cells;

	always_comb
	begin
		lines.x_line = holds_line(board.x_cells);
		lines.o_line = holds_line(board.o_cells);
		// the board is full once no cell is left empty
		lines.full = &taken;
	end

endmodule

`default_nettype wire

//--- verilog/board_store.sv
`timescale 1ns/1ps
`default_nettype none

// holds the two occupancy masks and answers whether the requested cell is free
// the legality decision itself is made in the FSM and this block only reports and writes
module board_store (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        new_game,
	input  wire ttt_pkg::cell_idx_t    move_cell,
	input  wire                        write_en,
	input  wire ttt_pkg::player_t      write_player,
	output logic                       cell_free,
	output ttt_pkg::board_t            board
);

	// occupancy padded out to the whole index range
	// indices 9 to 15 read as taken so they can never be free
	logic [15:0] occupied_ext;
	// one-hot select of the requested cell, all zero for indices past the board
	ttt_pkg::cell_mask_t cell_sel;

	assign occupied_ext = {7'h7f, board.x_cells | board.o_cells};
	assign cell_sel = ttt_pkg::cell_mask_t'(1) << move_cell;

	// a cell is free when it exists and nobody has played it yet
	assign cell_free = !occupied_ext[move_cell];

	always_ff @(posedge clk)
	begin
		if (reset || new_game)
		begin
			// a fresh game starts from an empty board
			board <= '0;
		end
		else if (write_en)
		begin
			// the mover's mask gains the selected cell
			case (write_player)
				ttt_pkg::X: board.x_cells <= board.x_cells | cell_sel;
				ttt_pkg::O: board.o_cells <= board.o_cells | cell_sel;
				default:
				begin
					// no owner, nothing to write
					board <= board;
				end
			endcase
		end
	end

	// a cell can belong to one player only
	// this guards the handshake between FSM legality and the write here
	a_masks_disjoint: assert property (
		@(posedge clk) disable iff (reset)
		(board.x_cells & board.o_cells) == '0
	);

endmodule

`default_nettype wire

//--- verilog/game_timer.sv
`timescale 1ns/1ps
`default_nettype none

// elapsed play time counter
// a cycle divider makes one tick per second, the tick advances a four digit BCD clock
module game_timer #(
	parameter int TICKS_PER_SECOND = 50_000_000
) (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        timer_clear,
	input  wire                        timer_run,
	output ttt_pkg::bcd_time_t         elapsed
);

	// divider width, kept at least one bit for a divisor of one
	localparam int DIV_W = (TICKS_PER_SECOND > 1) ? $clog2(TICKS_PER_SECOND) : 1;

	// running cycles seen since the last tick
	logic [DIV_W-1:0] div_count;
	// one cycle pulse on every TICKS_PER_SECOND-th running cycle
	logic tick;
	// elapsed has reached 99:59 and must not move further
	logic at_limit;

	assign tick = timer_run && (div_count == DIV_W'(TICKS_PER_SECOND - 1));

	assign at_limit = (elapsed.min_tens == 4'd9) && (elapsed.min_ones == 4'd9) &&
		(elapsed.sec_tens == 4'd5) && (elapsed.sec_ones == 4'd9);

	// the divider only counts while the game is running
	// so a paused game keeps its partial second
	always_ff @(posedge clk)
	begin
		if (reset || timer_clear)
			div_count <= '0;
		else if (tick)
			div_count <= '0;
		else if (timer_run)
			div_count <= div_count + 1'b1;
	end

	// BCD advance with a carry chain through the four digits
	always_ff @(posedge clk)
	begin
		if (reset || timer_clear)
		begin
			elapsed <= '0;
		end
		else if (tick && !at_limit)
		begin
			if (elapsed.sec_ones != 4'd9)
			begin
				elapsed.sec_ones <= elapsed.sec_ones + 4'd1;
			end
			else
			begin
				// seconds ones wrap and carry into the tens
				elapsed.sec_ones <= 4'd0;
				if (elapsed.sec_tens != 4'd5)
				begin
					elapsed.sec_tens <= elapsed.sec_tens + 4'd1;
				end
				else
				begin
					// a full minute has passed
					elapsed.sec_tens <= 4'd0;
					if (elapsed.min_ones != 4'd9)
					begin
						elapsed.min_ones <= elapsed.min_ones + 4'd1;
					end
					else
					begin
						// at_limit keeps min_tens from going past 9
						elapsed.min_ones <= 4'd0;
						elapsed.min_tens <= elapsed.min_tens + 4'd1;
					end
				end
			end
		end
	end

	// every digit stays a legal BCD value for its position
	a_bcd_digits_valid: assert property (
		@(posedge clk) disable iff (reset)
		(elapsed.sec_ones <= 4'd9) && (elapsed.sec_tens <= 4'd5) &&
		(elapsed.min_ones <= 4'd9) && (elapsed.min_tens <= 4'd9)
	);

endmodule

`default_nettype wire

//--- verilog/game_fsm.sv
`timescale 1ns/1ps
`default_nettype none

// turn and result control
// owns the move handshake and is the one place where a move is judged legal
module game_fsm (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        new_game,
	input  wire                        move_valid,
	input  wire ttt_pkg::cell_idx_t    move_cell,
	input  wire                        cell_free,
	input  wire ttt_pkg::line_result_t lines,
	output logic                       move_ready,
	output logic                       illegal_move,
	output logic                       write_en,
	output ttt_pkg::player_t           write_player,
	output ttt_pkg::game_result_t      result,
	output ttt_pkg::player_t           turn,
	output logic                       timer_run,
	output logic                       timer_clear
);

	// await a move, check the board one cycle after a write, or sit out a finished game
	typedef enum logic [1:0] {
		AWAIT_MOVE = 2'd0,
		CHECK      = 2'd1,
		GAME_OVER  = 2'd2
	} state_t;

	state_t state;
	// a move transfers on this cycle
	logic handshake;

	// moves are only taken while waiting for one
	// the check cycle and a finished game both hold ready low
	assign move_ready = (state == AWAIT_MOVE);
	assign handshake = move_valid && move_ready;

	// a transferred move is written only when the cell is free
	assign write_en = handshake && cell_free;
	assign write_player = turn;

	// the clock runs as long as nobody has won and the board is not drawn
	assign timer_run = (result == ttt_pkg::IN_PLAY);
	assign timer_clear = new_game;

	always_ff @(posedge clk)
	begin
		if (reset || new_game)
		begin
			// X always opens
			state        <= AWAIT_MOVE;
			turn         <= ttt_pkg::X;
			result       <= ttt_pkg::IN_PLAY;
			illegal_move <= 1'b0;
		end
		else
		begin
			// a refused move is flagged for exactly the cycle after it was taken
			illegal_move <= handshake && !cell_free;
			case (state)
				AWAIT_MOVE:
				begin
					// the turn stays put on a refused move
					if (write_en)
						state <= CHECK;
				end
				CHECK:
				begin
					// board now shows the new cell, rank the outcomes
					if (lines.x_line)
					begin
						result <= ttt_pkg::X_WINS;
						state  <= GAME_OVER;
					end
					else if (lines.o_line)
					begin
						result <= ttt_pkg::O_WINS;
						state  <= GAME_OVER;
					end
					else if (lines.full)
					begin
						result <= ttt_pkg::DRAW;
						state  <= GAME_OVER;
					end
					else
					begin
						// play goes on with the other player
						turn  <= (turn == ttt_pkg::X) ? ttt_pkg::O : ttt_pkg::X;
						state <= AWAIT_MOVE;
					end
				end
				GAME_OVER:
				begin
					// only new_game or reset leaves this state
					state <= GAME_OVER;
				end
				default:
				begin
					state <= AWAIT_MOVE;
				end
			endcase
		end
	end

	// a write only ever targets a cell that exists on the board
	a_write_in_range: assert property (
		@(posedge clk) disable iff (reset)
		write_en |-> (move_cell < 4'(ttt_pkg::CELL_COUNT))
	) else $error("write to invalid cell %0d", move_cell);

endmodule

`default_nettype wire

//--- verilog/tic_tac_toe_top.sv
`timescale 1ns/1ps
`default_nettype none

// tic-tac-toe engine
// moves come in on a valid/ready channel, the board and status go out as packed structs
module tic_tac_toe_top #(
	parameter int TICKS_PER_SECOND = 50_000_000
) (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        new_game,
	input  wire                        move_valid,
	input  wire ttt_pkg::cell_idx_t    move_cell,
	output logic                       move_ready,
	output logic                       illegal_move,
	output ttt_pkg::board_t            board,
	output ttt_pkg::game_status_t      status
);

	// FSM to board
	logic                  write_en;
	ttt_pkg::player_t      write_player;
	// board to FSM
	logic                  cell_free;
	// checker to FSM
	ttt_pkg::line_result_t lines;
	// FSM to timer
	logic                  timer_run;
	logic                  timer_clear;
	// pieces of the status word
	ttt_pkg::game_result_t result;
	ttt_pkg::player_t      turn;
	ttt_pkg::bcd_time_t    elapsed;

	game_fsm u_game_fsm (
		.clk          (clk),
		.reset        (reset),
		.new_game     (new_game),
		.move_valid   (move_valid),
		.move_cell    (move_cell),
		.cell_free    (cell_free),
		.lines        (lines),
		.move_ready   (move_ready),
		.illegal_move (illegal_move),
		.write_en     (write_en),
		.write_player (write_player),
		.result       (result),
		.turn         (turn),
		.timer_run    (timer_run),
		.timer_clear  (timer_clear)
	);

	board_store u_board_store (
		.clk          (clk),
		.reset        (reset),
		.new_game     (new_game),
		.move_cell    (move_cell),
		.write_en     (write_en),
		.write_player (write_player),
		.cell_free    (cell_free),
		.board        (board)
	);

	line_checker u_line_checker (
		.board (board),
		.lines (lines)
	);

	// the divisor comes from here so a testbench can shrink a second
	game_timer #(
		.TICKS_PER_SECOND (TICKS_PER_SECOND)
	) u_game_timer (
		.clk         (clk),
		.reset       (reset),
		.timer_clear (timer_clear),
		.timer_run   (timer_run),
		.elapsed     (elapsed)
	);

	// status gathers the outcome and turn from the FSM with the timer value
	assign status = '{result: result, turn: turn, elapsed: elapsed};

endmodule

`default_nettype wire

//--- tests/tb_tic_tac_toe.sv
`timescale 1ns/1ps
`default_nettype none

// self-checking testbench for the tic-tac-toe engine
// commands and expected values come from tests/game_stimulus.txt, one command per line
module tb_tic_tac_toe;

	// four cycles make one second, so timer behavior shows up within a few dozen cycles
	localparam int TICKS_PER_SECOND = 4;
	localparam int CLK_PERIOD = 10;
	// a move that sees ready low for this many cycles is treated as lost
	localparam int HANDSHAKE_LIMIT = 50;

	logic                  clk;
	logic                  reset;
	logic                  new_game;
	logic                  move_valid;
	ttt_pkg::cell_idx_t    move_cell;
	logic                  move_ready;
	logic                  illegal_move;
	ttt_pkg::board_t       board;
	ttt_pkg::game_status_t status;

	// one entry per command line of the stimulus file
	byte cmd_q[$];
	int  arg_q[$];
	int  result_q[$];
	int  turn_q[$];
	int  x_q[$];
	int  o_q[$];
	int  flag_q[$];
	int  secs_q[$];

	int   error_count;
	int   pass_count;
	// errors seen since the last finished test
	int   test_errors;
	int   watchdog_ns;
	logic watchdog_armed;

	tic_tac_toe_top #(
		.TICKS_PER_SECOND (TICKS_PER_SECOND)
	) DUT (
		.clk          (clk),
		.reset        (reset),
		.new_game     (new_game),
		.move_valid   (move_valid),
		.move_cell    (move_cell),
		.move_ready   (move_ready),
		.illegal_move (illegal_move),
		.board        (board),
		.status       (status)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// a run that outlives every command by a wide margin has hung somewhere
	initial
	begin
		wait (watchdog_armed);
		#(watchdog_ns);
		$display("timeout: the run was still going after %0d ns", watchdog_ns);
		$display("TEST FAIL");
		$finish;
	end

	task automatic compare_value(input string name, input int expected, input int actual);
		if (expected != actual)
		begin
			$display("Mismatch at %0t ns: %s expected 'h%0h, got 'h%0h",
				$time, name, expected, actual);
			error_count++;
			test_errors++;
		end
		else
			pass_count++;
	endtask

	// plain seconds written out as the mm:ss BCD word the timer should show
	function automatic int seconds_to_bcd(input int secs);
		int minutes;
		int seconds;
		minutes = secs / 60;
		seconds = secs % 60;
		return ((minutes / 10) << 12) | ((minutes % 10) << 8) |
			((seconds / 10) << 4) | (seconds % 10);
	endfunction

	// board, result, turn and time against one file line
	// a column holding -1 is skipped
	task automatic check_state(input int idx);
		if (result_q[idx] >= 0)
			compare_value("status.result", result_q[idx], int'(status.result));
		if (turn_q[idx] >= 0)
			compare_value("status.turn", turn_q[idx], int'(status.turn));
		compare_value("board.x_cells", x_q[idx], int'(board.x_cells));
		compare_value("board.o_cells", o_q[idx], int'(board.o_cells));
		if (secs_q[idx] >= 0)
			compare_value("status.elapsed", seconds_to_bcd(secs_q[idx]),
				int'(status.elapsed));
	endtask

	task automatic read_stimulus();
		int    fd;
		int    got;
		int    fields;
		string line_buf;
		byte   cmd;
		int    arg;
		int    res;
		int    trn;
		int    xm;
		int    om;
		int    flag;
		int    secs;
		fd = $fopen("tests/game_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("the stimulus file tests/game_stimulus.txt could not be opened");
			error_count++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line_buf = "";
				got = $fgets(line_buf, fd);
				// blank lines and comment lines carry no command
				if (got > 0 && line_buf.len() > 1 && line_buf[0] != "#")
				begin
					fields = $sscanf(line_buf, "%c %d %d %d %b %b %d %d",
						cmd, arg, res, trn, xm, om, flag, secs);
					if (fields != 8)
					begin
						$display("a stimulus line has %0d fields instead of 8: %s",
							fields, line_buf);
						error_count++;
					end
					else
					begin
						cmd_q.push_back(cmd);
						arg_q.push_back(arg);
						result_q.push_back(res);
						turn_q.push_back(trn);
						x_q.push_back(xm);
						o_q.push_back(om);
						flag_q.push_back(flag);
						secs_q.push_back(secs);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// every command task starts and ends at a falling edge
	task automatic play_move(input int idx);
		int waited;
		waited = 0;
		move_valid = 1'b1;
		move_cell = ttt_pkg::cell_idx_t'(arg_q[idx]);
		// ready comes from a register, so at the falling edge it already shows the next edge
		while (!move_ready && waited < HANDSHAKE_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!move_ready)
		begin
			$display("the move to cell %0d was never accepted", arg_q[idx]);
			error_count++;
			test_errors++;
			move_valid = 1'b0;
		end
		else
		begin
			// the transfer happens at the rising edge in between
			@(negedge clk);
			move_valid = 1'b0;
			compare_value("illegal_move", flag_q[idx], illegal_move);
			// a refused move keeps ready high and a legal one drops it for the check cycle
			compare_value("move_ready", flag_q[idx] != 0, move_ready);
			@(negedge clk);
			compare_value("illegal_move", 0, illegal_move);
			// ready only comes back while the game is still open
			if (result_q[idx] >= 0)
				compare_value("move_ready", result_q[idx] == 0, move_ready);
			check_state(idx);
		end
	endtask

	// an idle wait, or with a cell in the flag column a move left pending the whole time
	task automatic wait_cycles(input int idx);
		if (flag_q[idx] >= 0)
		begin
			move_valid = 1'b1;
			move_cell = ttt_pkg::cell_idx_t'(flag_q[idx]);
		end
		for (int i = 0; i < arg_q[idx]; i++)
		begin
			// ready high here would let the next rising edge take the pending move
			if (flag_q[idx] >= 0)
				compare_value("move_ready", 0, move_ready);
			@(negedge clk);
		end
		move_valid = 1'b0;
		check_state(idx);
	endtask

	task automatic start_new_game(input int idx);
		new_game = 1'b1;
		@(negedge clk);
		new_game = 1'b0;
		compare_value("move_ready", 1, move_ready);
		compare_value("illegal_move", flag_q[idx], illegal_move);
		check_state(idx);
	endtask

	task automatic finish_test(input int idx);
		if (flag_q[idx] >= 0)
			compare_value("illegal_move", flag_q[idx], illegal_move);
		check_state(idx);
		$display("test %0d finished with %0d errors", arg_q[idx], test_errors);
		test_errors = 0;
	endtask

	initial
	begin
		int total_wait;
		reset = 1'b1;
		new_game = 1'b0;
		move_valid = 1'b0;
		move_cell = '0;
		error_count = 0;
		pass_count = 0;
		test_errors = 0;
		watchdog_armed = 1'b0;
		read_stimulus();
		// time limit grows with the waits and the number of commands in the file
		total_wait = 0;
		foreach (cmd_q[i])
		begin
			if (cmd_q[i] == "W")
				total_wait += arg_q[i];
		end
		watchdog_ns = CLK_PERIOD * (total_wait + 20 * cmd_q.size() + 100);
		watchdog_armed = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < cmd_q.size(); i++)
		begin
			case (cmd_q[i])
				"M": play_move(i);
				"W": wait_cycles(i);
				"N": start_new_game(i);
				"C": finish_test(i);
				default:
				begin
					$display("unknown command %c on stimulus entry %0d", cmd_q[i], i);
					error_count++;
				end
			endcase
		end
		$display("%0d checks passed, %0d errors", pass_count, error_count);
		if (error_count == 0 && cmd_q.size() > 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
verilog/ttt_pkg.sv
verilog/line_checker.sv
verilog/board_store.sv
verilog/game_timer.sv
verilog/game_fsm.sv
verilog/tic_tac_toe_top.sv
tests/tb_tic_tac_toe.sv

//--- tests/game_stimulus.txt
# cmd arg result turn x_cells o_cells flag secs; M arg=cell flag=illegal, W arg=cycles flag=pending cell
# N/C flag=illegal, C arg=test; result 0 play 1 X 2 O 3 draw; turn 1 X 2 O; masks cell 8 left; -1 skips
C 0 0 1 000000000 000000000 0 0
M 0 0 2 000000001 000000000 0 -1
M 3 0 1 000000001 000001000 0 -1
M 1 0 2 000000011 000001000 0 -1
M 4 0 1 000000011 000011000 0 -1
M 2 1 1 000000111 000011000 0 -1
C 1 1 1 000000111 000011000 0 -1
N 0 0 1 000000000 000000000 0 0
M 0 0 2 000000001 000000000 0 -1
M 2 0 1 000000001 000000100 0 -1
M 1 0 2 000000011 000000100 0 -1
M 4 0 1 000000011 000010100 0 -1
M 3 0 2 000001011 000010100 0 -1
M 6 2 2 000001011 001010100 0 -1
C 2 2 2 000001011 001010100 0 -1
N 0 0 1 000000000 000000000 0 0
M 0 0 2 000000001 000000000 0 -1
M 1 0 1 000000001 000000010 0 -1
M 2 0 2 000000101 000000010 0 -1
M 4 0 1 000000101 000010010 0 -1
M 3 0 2 000001101 000010010 0 -1
M 5 0 1 000001101 000110010 0 -1
M 7 0 2 010001101 000110010 0 -1
M 6 0 1 010001101 001110010 0 -1
M 8 3 1 110001101 001110010 0 -1
C 3 3 1 110001101 001110010 0 -1
N 0 0 1 000000000 000000000 0 0
M 4 0 2 000010000 000000000 0 -1
M 4 0 2 000010000 000000000 1 -1
M 12 0 2 000010000 000000000 1 -1
M 0 0 1 000010000 000000001 0 -1
C 4 0 1 000010000 000000001 0 -1
M 2 0 2 000010100 000000001 0 -1
M 1 0 1 000010100 000000011 0 -1
M 6 1 1 001010100 000000011 0 -1
W 20 1 1 001010100 000000011 5 -1
C 5 1 1 001010100 000000011 0 -1
N 0 0 1 000000000 000000000 0 0
W 40 0 1 000000000 000000000 -1 10
M 0 0 2 000000001 000000000 0 -1
M 3 0 1 000000001 000001000 0 -1
M 1 0 2 000000011 000001000 0 -1
M 4 0 1 000000011 000011000 0 -1
M 2 1 1 000000111 000011000 0 12
W 40 1 1 000000111 000011000 -1 12
C 6 1 1 000000111 000011000 0 12
